// ==== common/pkt_buf_pkg.sv ====
`default_nettype none

// Sizes of one packet buffer and of the bundles that reach it
package pkt_buf_pkg;

	// Word address inside one buffer
	localparam int ADDR_WIDTH = 10;
	// Buffer word, also the stream word
	localparam int DATA_WIDTH = 64;
	// Byte count carried with each written word
	localparam int INC_WIDTH = 8;
	// Accumulated packet length in bytes
	localparam int PLEN_WIDTH = 32;
	localparam int BYTES_PER_WORD = 8;
	// Ping, pang and pong
	localparam int NUM_BUFS = 3;

	// Request toward a buffer: {addr, wr_data, wr_en, bytes_inc, rd_en}
	localparam int REQ_WIDTH = ADDR_WIDTH + DATA_WIDTH + 1 + INC_WIDTH + 1;
	// Response from a buffer: {rd_data, packet_len, has_buf}
	localparam int RSP_WIDTH = DATA_WIDTH + PLEN_WIDTH + 1;

endpackage

`default_nettype wire

// ==== common/buf_ctl_pkg.sv ====
`default_nettype none

// Buffer ownership and CPU verdict encodings
package buf_ctl_pkg;

	// Holder of one buffer, same order as the crossbar inputs
	typedef enum logic [1:0] {
		NONE  = 2'd0,
		SNOOP = 2'd1,
		CPU   = 2'd2,
		FWD   = 2'd3
	} buf_owner_t;

	// Buffer seen from an agent, zero when it holds nothing
	typedef enum logic [1:0] {
		NO_BUF = 2'd0,
		PING   = 2'd1,
		PANG   = 2'd2,
		PONG   = 2'd3
	} buf_id_t;

	typedef enum logic {DROP = 1'b0, FORWARD = 1'b1} verdict_t;

endpackage

`default_nettype wire

// ==== common/buf_port_if.sv ====
`timescale 1ns/100ps
`default_nettype none

// One access path between an agent and a packet buffer
interface buf_port_if;
	import pkt_buf_pkg::*;

	// Requests from the agent side
	logic [ADDR_WIDTH-1:0] addr;
	logic [DATA_WIDTH-1:0] wr_data;
	logic wr_en;
	logic [INC_WIDTH-1:0] bytes_inc;
	logic rd_en;

	// Responses from the buffer side
	logic [DATA_WIDTH-1:0] rd_data;
	logic [PLEN_WIDTH-1:0] packet_len;
	// High while a buffer is attached to this path
	logic has_buf;

	modport agent (
		output addr, wr_data, wr_en, bytes_inc, rd_en,
		input rd_data, packet_len, has_buf
	);

	modport buffer (
		input addr, wr_data, wr_en, bytes_inc, rd_en,
		output rd_data, packet_len, has_buf
	);

endinterface

`default_nettype wire

// ==== hw/pkt_buf/pkt_buf.sv ====
`timescale 1ns/100ps
`default_nettype none

module pkt_buf (
	input logic clk,
	input logic rst,
	input logic clear_len,
	buf_port_if.buffer port
);
	import pkt_buf_pkg::*;

	// One packet worth of words
	logic [DATA_WIDTH-1:0] mem [1 << ADDR_WIDTH];
	logic [PLEN_WIDTH-1:0] len_q;
	logic [PLEN_WIDTH-1:0] len_base;
	logic [PLEN_WIDTH-1:0] len_add;

	// Fresh count starts from zero when handed to the snooper
	assign len_base = clear_len ? '0 : len_q;
	// A write in the clearing cycle still counts its bytes
	assign len_add = port.wr_en ? PLEN_WIDTH'(port.bytes_inc) : '0;

	// Write and registered read share the one address
	always_ff @(posedge clk) begin
		if (port.wr_en) begin
			mem[port.addr] <= port.wr_data;
		end
		if (port.rd_en) begin
			port.rd_data <= mem[port.addr];
		end
	end

	// Byte length grows with every stored word
	always_ff @(posedge clk) begin
		if (rst) begin
			len_q <= '0;
		end else begin
			len_q <= len_base + len_add;
		end
	end

	assign port.packet_len = len_q;
	// Always present here, crossbar zeros it for agents that do not own us
	assign port.has_buf = 1'b1;

endmodule

`default_nettype wire

// ==== hw/buf_xbar/buf_xbar.sv ====
`timescale 1ns/100ps
`default_nettype none

module buf_xbar (
	input buf_ctl_pkg::buf_owner_t owner_ping,
	input buf_ctl_pkg::buf_owner_t owner_pang,
	input buf_ctl_pkg::buf_owner_t owner_pong,
	buf_port_if.buffer sn,
	buf_port_if.buffer cpu,
	buf_port_if.buffer fwd,
	buf_port_if.agent ping,
	buf_port_if.agent pang,
	buf_port_if.agent pong
);
	import pkt_buf_pkg::*;
	import buf_ctl_pkg::*;

	logic [REQ_WIDTH-1:0] sn_req;
	logic [REQ_WIDTH-1:0] cpu_req;
	logic [REQ_WIDTH-1:0] fwd_req;
	logic [RSP_WIDTH-1:0] ping_rsp;
	logic [RSP_WIDTH-1:0] pang_rsp;
	logic [RSP_WIDTH-1:0] pong_rsp;
	buf_id_t sn_sel;
	buf_id_t cpu_sel;
	buf_id_t fwd_sel;

	// Which buffer a given agent currently holds
	function automatic buf_id_t held_by(
		input buf_owner_t who,
		input buf_owner_t own_a,
		input buf_owner_t own_b,
		input buf_owner_t own_c
	);
		if (own_a == who) return PING;
		if (own_b == who) return PANG;
		if (own_c == who) return PONG;
		return NO_BUF;
	endfunction

	// Buffer side mux, owner code picks the agent
	function automatic logic [REQ_WIDTH-1:0] route_req(
		input buf_owner_t own,
		input logic [REQ_WIDTH-1:0] from_sn,
		input logic [REQ_WIDTH-1:0] from_cpu,
		input logic [REQ_WIDTH-1:0] from_fwd
	);
		case (own)
			SNOOP: return from_sn;
			CPU: return from_cpu;
			FWD: return from_fwd;
			default: return '0;
		endcase
	endfunction

	// Agent side mux, zeros when nothing is held
	function automatic logic [RSP_WIDTH-1:0] route_rsp(
		input buf_id_t sel,
		input logic [RSP_WIDTH-1:0] from_ping,
		input logic [RSP_WIDTH-1:0] from_pang,
		input logic [RSP_WIDTH-1:0] from_pong
	);
		case (sel)
			PING: return from_ping;
			PANG: return from_pang;
			PONG: return from_pong;
			default: return '0;
		endcase
	endfunction

	assign sn_sel = held_by(SNOOP, owner_ping, owner_pang, owner_pong);
	assign cpu_sel = held_by(CPU, owner_ping, owner_pang, owner_pong);
	assign fwd_sel = held_by(FWD, owner_ping, owner_pang, owner_pong);

	// Snooper never reads, CPU and forwarder never write
	assign sn_req = {sn.addr, sn.wr_data, sn.wr_en, sn.bytes_inc, 1'b0};
	assign cpu_req = {cpu.addr, {DATA_WIDTH{1'b0}}, 1'b0, {INC_WIDTH{1'b0}}, cpu.rd_en};
	assign fwd_req = {fwd.addr, {DATA_WIDTH{1'b0}}, 1'b0, {INC_WIDTH{1'b0}}, fwd.rd_en};

	assign {ping.addr, ping.wr_data, ping.wr_en, ping.bytes_inc, ping.rd_en} =
		route_req(owner_ping, sn_req, cpu_req, fwd_req);
	assign {pang.addr, pang.wr_data, pang.wr_en, pang.bytes_inc, pang.rd_en} =
		route_req(owner_pang, sn_req, cpu_req, fwd_req);
	assign {pong.addr, pong.wr_data, pong.wr_en, pong.bytes_inc, pong.rd_en} =
		route_req(owner_pong, sn_req, cpu_req, fwd_req);

	assign ping_rsp = {ping.rd_data, ping.packet_len, ping.has_buf};
	assign pang_rsp = {pang.rd_data, pang.packet_len, pang.has_buf};
	assign pong_rsp = {pong.rd_data, pong.packet_len, pong.has_buf};

	assign {sn.rd_data, sn.packet_len, sn.has_buf} =
		route_rsp(sn_sel, ping_rsp, pang_rsp, pong_rsp);
	assign {cpu.rd_data, cpu.packet_len, cpu.has_buf} =
		route_rsp(cpu_sel, ping_rsp, pang_rsp, pong_rsp);
	assign {fwd.rd_data, fwd.packet_len, fwd.has_buf} =
		route_rsp(fwd_sel, ping_rsp, pang_rsp, pong_rsp);

endmodule

`default_nettype wire

// ==== hw/ring_sched/ring_sched.sv ====
`timescale 1ns/100ps
`default_nettype none

module ring_sched (
	input logic clk,
	input logic rst,
	input logic snoop_done,
	input logic cpu_release,
	input logic fwd_done,
	input buf_ctl_pkg::verdict_t cpu_verdict,
	output buf_ctl_pkg::buf_owner_t owner_ping,
	output buf_ctl_pkg::buf_owner_t owner_pang,
	output buf_ctl_pkg::buf_owner_t owner_pong,
	output logic clear_ping,
	output logic clear_pang,
	output logic clear_pong
);
	import pkt_buf_pkg::*;
	import buf_ctl_pkg::*;

	buf_owner_t owner [NUM_BUFS];
	// One pointer per stage, each walks the ring in the same order
	logic [$clog2(NUM_BUFS)-1:0] sn_ptr;
	logic [$clog2(NUM_BUFS)-1:0] cpu_ptr;
	logic [$clog2(NUM_BUFS)-1:0] fwd_ptr;
	logic [NUM_BUFS-1:0] clear_q;

	function automatic logic [$clog2(NUM_BUFS)-1:0] next_ptr(
		input logic [$clog2(NUM_BUFS)-1:0] p
	);
		return (int'(p) == NUM_BUFS - 1) ? '0 : p + 1'b1;
	endfunction

	// Only the oldest buffer of the CPU and forwarder stages reaches its agent
	function automatic buf_owner_t shown_owner(
		input buf_owner_t own,
		input logic [$clog2(NUM_BUFS)-1:0] idx,
		input logic [$clog2(NUM_BUFS)-1:0] cpu_at,
		input logic [$clog2(NUM_BUFS)-1:0] fwd_at
	);
		if (own == CPU && idx != cpu_at) begin
			return NONE;
		end
		if (own == FWD && idx != fwd_at) begin
			return NONE;
		end
		return own;
	endfunction

	// Stage pointers target buffers with distinct owners, so updates never collide
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < NUM_BUFS; i++) begin
				owner[i] <= NONE;
			end
			sn_ptr <= '0;
			cpu_ptr <= '0;
			fwd_ptr <= '0;
			clear_q <= '0;
		end else begin
			clear_q <= '0;
			// Snooper hands its packet on, or picks up the next free buffer
			if (snoop_done) begin
				owner[sn_ptr] <= CPU;
				sn_ptr <= next_ptr(sn_ptr);
			end else if (owner[sn_ptr] == NONE) begin
				owner[sn_ptr] <= SNOOP;
				clear_q[sn_ptr] <= 1'b1;
			end
			if (cpu_release) begin
				owner[cpu_ptr] <= (cpu_verdict == FORWARD) ? FWD : NONE;
				cpu_ptr <= next_ptr(cpu_ptr);
			end
			// Forwarder steps past dropped buffers already released by the CPU
			if (fwd_done) begin
				owner[fwd_ptr] <= NONE;
				fwd_ptr <= next_ptr(fwd_ptr);
			end else if (owner[fwd_ptr] == NONE && fwd_ptr != cpu_ptr) begin
				fwd_ptr <= next_ptr(fwd_ptr);
			end
		end
	end

	// Queued packets stay hidden until their stage pointer arrives
	assign owner_ping = shown_owner(owner[0], 2'd0, cpu_ptr, fwd_ptr);
	assign owner_pang = shown_owner(owner[1], 2'd1, cpu_ptr, fwd_ptr);
	assign owner_pong = shown_owner(owner[2], 2'd2, cpu_ptr, fwd_ptr);

	assign clear_ping = clear_q[0];
	assign clear_pang = clear_q[1];
	assign clear_pong = clear_q[2];

endmodule

`default_nettype wire

// ==== hw/snoop_wr.sv ====
`timescale 1ns/100ps
`default_nettype none

module snoop_wr (
	input logic clk,
	input logic rst,
	input logic in_valid,
	input logic in_last,
	input logic [pkt_buf_pkg::DATA_WIDTH-1:0] in_data,
	input logic [pkt_buf_pkg::INC_WIDTH-1:0] in_bytes,
	output logic in_ready,
	output logic snoop_done,
	buf_port_if.agent port
);
	import pkt_buf_pkg::*;

	logic fire;
	// Packet finished, old buffer not yet taken away
	logic done_wait;
	logic [ADDR_WIDTH-1:0] wr_addr;

	// Back-pressure until a buffer is held and the last packet is handed off
	assign in_ready = port.has_buf && !done_wait;
	assign fire = in_valid && in_ready;

	// Every accepted word becomes one buffer write
	assign port.addr = wr_addr;
	assign port.wr_data = in_data;
	assign port.wr_en = fire;
	assign port.bytes_inc = in_bytes;
	assign port.rd_en = 1'b0;

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_addr <= '0;
			done_wait <= 1'b0;
			snoop_done <= 1'b0;
		end else begin
			snoop_done <= fire && in_last;
			if (fire) begin
				if (in_last) begin
					// Next packet starts at word zero
					wr_addr <= '0;
					done_wait <= 1'b1;
				end else begin
					wr_addr <= wr_addr + 1'b1;
				end
			end else if (snoop_done) begin
				// Ownership moves on at this edge
				done_wait <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/fwd_rd.sv ====
`timescale 1ns/100ps
`default_nettype none

module fwd_rd (
	input logic clk,
	input logic rst,
	input logic out_ready,
	output logic out_valid,
	output logic out_last,
	output logic fwd_done,
	output logic [pkt_buf_pkg::DATA_WIDTH-1:0] out_data,
	output logic [pkt_buf_pkg::INC_WIDTH-1:0] out_bytes,
	buf_port_if.agent port
);
	import pkt_buf_pkg::*;

	logic issue;
	logic out_free;
	// All words of the current packet requested
	logic issued_all;
	logic rd_inflight;
	logic inflight_last;
	logic [INC_WIDTH-1:0] inflight_bytes;
	logic skid_valid;
	logic skid_last;
	logic [DATA_WIDTH-1:0] skid_data;
	logic [INC_WIDTH-1:0] skid_bytes;
	logic [ADDR_WIDTH-1:0] rd_addr;
	logic [PLEN_WIDTH-1:0] last_word;
	logic word_last;
	logic [$clog2(BYTES_PER_WORD)-1:0] tail_rem;
	logic [INC_WIDTH-1:0] tail_bytes;

	// Index of the final word and its byte count
	assign last_word = (port.packet_len - 1'b1) >> $clog2(BYTES_PER_WORD);
	assign word_last = rd_addr == last_word[ADDR_WIDTH-1:0];
	assign tail_rem = port.packet_len[$clog2(BYTES_PER_WORD)-1:0];
	assign tail_bytes = (tail_rem == '0) ? INC_WIDTH'(BYTES_PER_WORD) : INC_WIDTH'(tail_rem);

	assign out_free = !out_valid || out_ready;
	// Never more words in flight than output plus skid can hold
	assign issue = port.has_buf && !issued_all && !skid_valid && !(rd_inflight && !out_free);

	assign port.addr = rd_addr;
	assign port.rd_en = issue;
	assign port.wr_en = 1'b0;
	assign port.wr_data = '0;
	assign port.bytes_inc = '0;

	always_ff @(posedge clk) begin
		if (rst) begin
			rd_addr <= '0;
			issued_all <= 1'b0;
			rd_inflight <= 1'b0;
			skid_valid <= 1'b0;
			out_valid <= 1'b0;
			fwd_done <= 1'b0;
		end else begin
			fwd_done <= out_valid && out_ready && out_last;
			rd_inflight <= issue;
			if (issue) begin
				if (word_last) begin
					issued_all <= 1'b1;
					rd_addr <= '0;
				end else begin
					rd_addr <= rd_addr + 1'b1;
				end
			end else if (fwd_done) begin
				// Next buffer may follow without a gap in has_buf
				issued_all <= 1'b0;
			end
			// Skid drains first, it is always the older word
			if (out_free) begin
				out_valid <= skid_valid || rd_inflight;
				skid_valid <= 1'b0;
			end else if (rd_inflight) begin
				skid_valid <= 1'b1;
			end
		end
	end

	// Word tags travel with the read, data lands a cycle later
	always_ff @(posedge clk) begin
		if (issue) begin
			inflight_last <= word_last;
			inflight_bytes <= word_last ? tail_bytes : INC_WIDTH'(BYTES_PER_WORD);
		end
		if (out_free) begin
			if (skid_valid) begin
				out_data <= skid_data;
				out_bytes <= skid_bytes;
				out_last <= skid_last;
			end else begin
				out_data <= port.rd_data;
				out_bytes <= inflight_bytes;
				out_last <= inflight_last;
			end
		end else if (rd_inflight) begin
			skid_data <= port.rd_data;
			skid_bytes <= inflight_bytes;
			skid_last <= inflight_last;
		end
	end

endmodule

`default_nettype wire

// ==== hw/cpu_wb.sv ====
`timescale 1ns/100ps
`default_nettype none

module cpu_wb (
	input logic clk,
	input logic rst,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input logic [11:0] wb_adr,
	input logic [31:0] wb_dat_w,
	output logic [31:0] wb_dat_r,
	output logic wb_ack,
	output logic cpu_release,
	output buf_ctl_pkg::verdict_t cpu_verdict,
	buf_port_if.agent port
);
	import pkt_buf_pkg::*;
	import buf_ctl_pkg::*;

	// New cycle not yet being served
	logic req;
	logic buf_rd;
	logic is_release;
	logic rd_wait;
	logic rd_hi;

	assign req = wb_cyc && wb_stb && !wb_ack && !rd_wait;
	// Bit 11 clear selects buffer words
	assign buf_rd = req && !wb_we && !wb_adr[11];
	assign is_release = req && wb_we && wb_adr == 12'h802;

	// Word index sits above the half select bit
	assign port.addr = wb_adr[ADDR_WIDTH:1];
	assign port.rd_en = buf_rd;
	assign port.wr_en = 1'b0;
	assign port.wr_data = '0;
	assign port.bytes_inc = '0;

	always_ff @(posedge clk) begin
		if (rst) begin
			wb_ack <= 1'b0;
			rd_wait <= 1'b0;
			cpu_release <= 1'b0;
		end else begin
			wb_ack <= 1'b0;
			cpu_release <= 1'b0;
			if (rd_wait) begin
				// Buffer data arrived, ack two cycles after stb
				rd_wait <= 1'b0;
				wb_ack <= 1'b1;
			end else if (buf_rd) begin
				rd_wait <= 1'b1;
			end else if (req) begin
				wb_ack <= 1'b1;
				// A release without a buffer is ignored
				cpu_release <= is_release && port.has_buf;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (buf_rd) begin
			rd_hi <= wb_adr[0];
		end
		if (rd_wait) begin
			wb_dat_r <= rd_hi ? port.rd_data[DATA_WIDTH-1 -: 32] : port.rd_data[31:0];
		end else if (req && !wb_we) begin
			case (wb_adr)
				12'h800: wb_dat_r <= port.packet_len;
				12'h801: wb_dat_r <= {31'b0, port.has_buf};
				default: wb_dat_r <= '0;
			endcase
		end
		if (is_release) begin
			cpu_verdict <= verdict_t'(wb_dat_w[0]);
		end
	end

endmodule

`default_nettype wire

// ==== hw/pkt_filter_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module pkt_filter_top (
	input logic clk,
	input logic rst,
	// Snooper stream in
	input logic in_valid,
	output logic in_ready,
	input logic [pkt_buf_pkg::DATA_WIDTH-1:0] in_data,
	input logic [pkt_buf_pkg::INC_WIDTH-1:0] in_bytes,
	input logic in_last,
	// Forwarded stream out
	output logic out_valid,
	input logic out_ready,
	output logic [pkt_buf_pkg::DATA_WIDTH-1:0] out_data,
	output logic [pkt_buf_pkg::INC_WIDTH-1:0] out_bytes,
	output logic out_last,
	// CPU Wishbone slave
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input logic [11:0] wb_adr,
	input logic [31:0] wb_dat_w,
	output logic [31:0] wb_dat_r,
	output logic wb_ack
);
	import buf_ctl_pkg::*;

	buf_owner_t owner_ping;
	buf_owner_t owner_pang;
	buf_owner_t owner_pong;
	verdict_t cpu_verdict;
	logic clear_ping;
	logic clear_pang;
	logic clear_pong;
	logic snoop_done;
	logic cpu_release;
	logic fwd_done;

	// Agent side paths
	buf_port_if sn_if ();
	buf_port_if cpu_if ();
	buf_port_if fwd_if ();
	// Buffer side paths
	buf_port_if ping_if ();
	buf_port_if pang_if ();
	buf_port_if pong_if ();

	snoop_wr u_snoop (
		.clk(clk), .rst(rst), .in_valid(in_valid), .in_last(in_last),
		.in_data(in_data), .in_bytes(in_bytes), .in_ready(in_ready),
		.snoop_done(snoop_done), .port(sn_if)
	);

	cpu_wb u_cpu (
		.clk(clk), .rst(rst), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
		.wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
		.cpu_release(cpu_release), .cpu_verdict(cpu_verdict), .port(cpu_if)
	);

	fwd_rd u_fwd (
		.clk(clk), .rst(rst), .out_ready(out_ready), .out_valid(out_valid),
		.out_last(out_last), .fwd_done(fwd_done), .out_data(out_data),
		.out_bytes(out_bytes), .port(fwd_if)
	);

	ring_sched u_sched (
		.clk(clk), .rst(rst), .snoop_done(snoop_done), .cpu_release(cpu_release),
		.fwd_done(fwd_done), .cpu_verdict(cpu_verdict),
		.owner_ping(owner_ping), .owner_pang(owner_pang), .owner_pong(owner_pong),
		.clear_ping(clear_ping), .clear_pang(clear_pang), .clear_pong(clear_pong)
	);

	buf_xbar u_xbar (
		.owner_ping(owner_ping), .owner_pang(owner_pang), .owner_pong(owner_pong),
		.sn(sn_if), .cpu(cpu_if), .fwd(fwd_if),
		.ping(ping_if), .pang(pang_if), .pong(pong_if)
	);

	pkt_buf u_ping (.clk(clk), .rst(rst), .clear_len(clear_ping), .port(ping_if));
	pkt_buf u_pang (.clk(clk), .rst(rst), .clear_len(clear_pang), .port(pang_if));
	pkt_buf u_pong (.clk(clk), .rst(rst), .clear_len(clear_pong), .port(pong_if));

endmodule

`default_nettype wire

// ==== dv/pkt_filter_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module pkt_filter_tb;
	import pkt_buf_pkg::*;

	localparam int NUM_PACKETS = 60;
	localparam int MAX_LEN = 40;
	// Longest wait allowed in any polling loop
	localparam int TIMEOUT_CYCLES = 5000;

	logic clk = 1'b0;
	logic rst;
	logic in_valid;
	logic in_ready;
	logic [DATA_WIDTH-1:0] in_data;
	logic [INC_WIDTH-1:0] in_bytes;
	logic in_last;
	logic out_valid;
	logic out_ready;
	logic [DATA_WIDTH-1:0] out_data;
	logic [INC_WIDTH-1:0] out_bytes;
	logic out_last;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [11:0] wb_adr;
	logic [31:0] wb_dat_w;
	logic [31:0] wb_dat_r;
	logic wb_ack;

	// Model of all packets in arrival order
	int sent_lens[$];
	logic [DATA_WIDTH-1:0] sent_words[$];
	// Forwarded subset, in the order it must leave
	int fwd_lens[$];
	logic [DATA_WIDTH-1:0] fwd_words[$];
	// Completed packets minus freed ones, freed counted slightly early
	int completed = 0;
	int freed = 0;
	int full_seen = 0;
	logic cpu_finished = 1'b0;

	always #5 clk = ~clk;

	pkt_filter_top u_dut (
		.clk(clk), .rst(rst),
		.in_valid(in_valid), .in_ready(in_ready), .in_data(in_data),
		.in_bytes(in_bytes), .in_last(in_last),
		.out_valid(out_valid), .out_ready(out_ready), .out_data(out_data),
		.out_bytes(out_bytes), .out_last(out_last),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack)
	);

	task automatic stop_run();
		$display(">>> FAIL");
		$fatal(1, "Simulation stopped on the first error");
	endtask

	task automatic check_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		if (expected !== actual) begin
			$display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
			stop_run();
		end
	endtask

	// Offer one word at the falling edge and hold it until taken
	task automatic send_word(input logic [63:0] data, input int bytes, input logic last);
		int waited;
		waited = 0;
		in_valid = 1'b1;
		in_data = data;
		in_bytes = INC_WIDTH'(bytes);
		in_last = last;
		// in_ready only moves on rising edges
		while (!in_ready) begin
			@(negedge clk);
			waited++;
			if (waited > TIMEOUT_CYCLES) begin
				$display("Timed out waiting for in_ready");
				stop_run();
			end
		end
		@(negedge clk);
		in_valid = 1'b0;
	endtask

	task automatic send_packets();
		int len;
		int nwords;
		logic [63:0] word;
		for (int p = 0; p < NUM_PACKETS; p++) begin
			len = int'($urandom_range(MAX_LEN, 1));
			nwords = (len + BYTES_PER_WORD - 1) / BYTES_PER_WORD;
			sent_lens.push_back(len);
			for (int i = 0; i < nwords; i++) begin
				word[63:32] = $urandom;
				word[31:0] = $urandom;
				sent_words.push_back(word);
				// Full words except a short tail
				send_word(word, (i == nwords - 1) ? len - i * BYTES_PER_WORD : BYTES_PER_WORD,
					i == nwords - 1);
				if ($urandom_range(3, 0) == 0) begin
					repeat ($urandom_range(3, 1)) @(negedge clk);
				end
			end
			completed++;
		end
	endtask

	// One Wishbone classic cycle, started on a falling edge
	task automatic bus_access(input logic we, input logic [11:0] adr, input logic [31:0] wdat,
		output logic [31:0] rdat);
		int waited;
		waited = 0;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = we;
		wb_adr = adr;
		wb_dat_w = wdat;
		do begin
			@(negedge clk);
			waited++;
			if (waited > TIMEOUT_CYCLES) begin
				$display("Timed out waiting for wb_ack at address %h", adr);
				stop_run();
			end
		end while (!wb_ack);
		// Buffer words pay one more cycle for the memory read
		check_value("ack latency", (!we && !adr[11]) ? 64'd2 : 64'd1, 64'(waited));
		rdat = wb_dat_r;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		// Idle cycle lets ack drop before the next request
		@(negedge clk);
	endtask

	task automatic serve_cpu();
		int len;
		int nwords;
		int polls;
		logic [31:0] rd;
		logic [63:0] word;
		logic forward;
		for (int p = 0; p < NUM_PACKETS; p++) begin
			// Slow CPU so the ring fills up
			repeat ($urandom_range(80, 0)) @(negedge clk);
			polls = 0;
			bus_access(1'b0, 12'h801, 32'd0, rd);
			while (rd[0] !== 1'b1) begin
				polls++;
				if (polls > TIMEOUT_CYCLES) begin
					$display("Timed out waiting for the CPU to get packet %0d", p);
					stop_run();
				end
				bus_access(1'b0, 12'h801, 32'd0, rd);
			end
			if (sent_lens.size() == 0) begin
				$display("CPU was handed a buffer while no packet was sent");
				stop_run();
			end
			len = sent_lens.pop_front();
			nwords = (len + BYTES_PER_WORD - 1) / BYTES_PER_WORD;
			bus_access(1'b0, 12'h800, 32'd0, rd);
			check_value($sformatf("packet %0d length", p), 64'(len), 64'(rd));
			forward = ($urandom_range(1, 0) == 1);
			for (int i = 0; i < nwords; i++) begin
				word = sent_words.pop_front();
				bus_access(1'b0, {1'b0, 10'(i), 1'b0}, 32'd0, rd);
				check_value($sformatf("packet %0d word %0d low", p, i), 64'(word[31:0]), 64'(rd));
				bus_access(1'b0, {1'b0, 10'(i), 1'b1}, 32'd0, rd);
				check_value($sformatf("packet %0d word %0d high", p, i), 64'(word[63:32]),
					64'(rd));
				if (forward) begin
					fwd_words.push_back(word);
				end
			end
			if (forward) begin
				fwd_lens.push_back(len);
			end
			bus_access(1'b1, 12'h802, {31'd0, forward}, rd);
			if (!forward) begin
				freed++;
			end
			// Ownership moves a cycle after the release
			repeat (2) @(negedge clk);
		end
		cpu_finished = 1'b1;
	endtask

	task automatic watch_output();
		int idle;
		int quiet;
		int word_idx;
		int len;
		int nwords;
		int exp_bytes;
		logic stalled;
		logic [63:0] held_data;
		logic [7:0] held_bytes;
		logic held_last;
		idle = 0;
		quiet = 0;
		word_idx = 0;
		stalled = 1'b0;
		held_data = '0;
		held_bytes = '0;
		held_last = 1'b0;
		while (quiet < 50) begin
			@(negedge clk);
			// Three held packets leave no buffer for the snooper
			if (completed - freed >= NUM_BUFS) begin
				full_seen++;
				check_value("in_ready with all buffers busy", 64'd0, 64'(in_ready));
			end
			// Stalled word waits unchanged
			if (stalled) begin
				check_value("out_valid under stall", 64'd1, 64'(out_valid));
				check_value("out_data under stall", held_data, out_data);
				check_value("out_bytes under stall", 64'(held_bytes), 64'(out_bytes));
				check_value("out_last under stall", 64'(held_last), 64'(out_last));
			end
			out_ready = ($urandom_range(3, 0) != 0);
			if (out_valid && out_ready) begin
				if (fwd_lens.size() == 0) begin
					$display("Output word seen while no forwarded packet was pending");
					stop_run();
				end
				len = fwd_lens[0];
				nwords = (len + BYTES_PER_WORD - 1) / BYTES_PER_WORD;
				exp_bytes = BYTES_PER_WORD;
				// Tail carries the remainder, a full word when it is zero
				if (word_idx == nwords - 1 && len % BYTES_PER_WORD != 0) begin
					exp_bytes = len % BYTES_PER_WORD;
				end
				check_value("out_data", fwd_words.pop_front(), out_data);
				check_value("out_bytes", 64'(exp_bytes), 64'(out_bytes));
				check_value("out_last", 64'(word_idx == nwords - 1), 64'(out_last));
				word_idx++;
				if (word_idx == nwords) begin
					len = fwd_lens.pop_front();
					word_idx = 0;
					freed++;
				end
				idle = 0;
			end else if (fwd_lens.size() != 0) begin
				idle++;
				if (idle > TIMEOUT_CYCLES) begin
					$display("Timed out waiting for a forwarded word");
					stop_run();
				end
			end
			stalled = out_valid && !out_ready;
			held_data = out_data;
			held_bytes = out_bytes;
			held_last = out_last;
			if (cpu_finished && fwd_lens.size() == 0) begin
				quiet++;
			end
		end
	endtask

	initial begin
		logic [31:0] rd;
		int waited;
		void'($urandom(32'hc948));
		rst = 1'b1;
		in_valid = 1'b0;
		in_data = '0;
		in_bytes = '0;
		in_last = 1'b0;
		out_ready = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		repeat (2) @(negedge clk);
		rst = 1'b0;
		check_value("in_ready after reset", 64'd0, 64'(in_ready));
		check_value("out_valid after reset", 64'd0, 64'(out_valid));
		check_value("wb_ack after reset", 64'd0, 64'(wb_ack));
		// Ping reaches the snooper shortly after reset
		waited = 0;
		while (!in_ready) begin
			@(negedge clk);
			waited++;
			if (waited > TIMEOUT_CYCLES) begin
				$display("Timed out waiting for in_ready after reset");
				stop_run();
			end
		end
		bus_access(1'b0, 12'h801, 32'd0, rd);
		check_value("has_buf before first packet", 64'd0, 64'(rd));
		check_value("out_valid before first packet", 64'd0, 64'(out_valid));
		fork
			send_packets();
			serve_cpu();
			watch_output();
		join
		if (sent_lens.size() == 0 && sent_words.size() == 0 && fwd_words.size() == 0 &&
			full_seen > 0) begin
			$display(">>> PASS");
			$finish;
		end else begin
			$display("Run ended with %0d unread packets, %0d unsent words, %0d full cycles",
				sent_lens.size(), fwd_words.size(), full_seen);
			stop_run();
		end
	end

endmodule

`default_nettype wire

// ==== files.f ====
common/pkt_buf_pkg.sv
common/buf_ctl_pkg.sv
common/buf_port_if.sv
hw/pkt_buf/pkt_buf.sv
hw/buf_xbar/buf_xbar.sv
hw/ring_sched/ring_sched.sv
hw/snoop_wr.sv
hw/fwd_rd.sv
hw/cpu_wb.sv
hw/pkt_filter_top.sv
dv/pkt_filter_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the packet filter testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 -f files.f --top-module pkt_filter_tb -o pkt_filter_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/pkt_filter_sim)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx '>>> PASS'; then
	exit 0
fi
echo "Pass line not found in simulation output"
exit 1
